// ==== common/controlPkg.sv ====
package controlPkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;     // Bits 31..26
    typedef logic [5:0]  funct_t;      // Bits 5..0
    typedef logic [4:0]  regField_t;   // rt or shamt sub-field

    typedef logic [4:0]  aluCode_t;
    typedef logic [1:0]  regDst_t;
    typedef logic [1:0]  dataType_t;
    typedef logic [1:0]  hiLoWrite_t;

    // Control word handed to the execute stage
    typedef struct packed {
        regDst_t    regDst;
        logic       aluSrcImm;     // Second operand from immediate
        logic       aluSrcShamt;   // Shift amount from instruction
        logic       memToReg;
        logic       regWrite;
        hiLoWrite_t hiLoWrite;
        logic       memRead;
        logic       memWrite;
        logic       branch;
        logic       jump;
        dataType_t  dataType;
        logic       signExtend;
        aluCode_t   aluCode;
    } ctrlWord_t;

    // R-format extras out of the funct decode
    typedef struct packed {
        aluCode_t   aluCode;
        hiLoWrite_t hiLoWrite;
        logic       aluSrcShamt;
        logic       jumpReg;
    } rFormatCtrl_t;

    localparam opcode_t OP_SPECIAL  = 6'b000000;
    localparam opcode_t OP_REGIMM   = 6'b000001;
    localparam opcode_t OP_J        = 6'b000010;
    localparam opcode_t OP_JAL      = 6'b000011;
    localparam opcode_t OP_BEQ      = 6'b000100;
    localparam opcode_t OP_BNE      = 6'b000101;
    localparam opcode_t OP_BLEZ     = 6'b000110;
    localparam opcode_t OP_BGTZ     = 6'b000111;
    localparam opcode_t OP_ADDI     = 6'b001000;
    localparam opcode_t OP_ADDIU    = 6'b001001;
    localparam opcode_t OP_SLTI     = 6'b001010;
    localparam opcode_t OP_SLTIU    = 6'b001011;
    localparam opcode_t OP_ANDI     = 6'b001100;
    localparam opcode_t OP_ORI      = 6'b001101;
    localparam opcode_t OP_XORI     = 6'b001110;
    localparam opcode_t OP_LUI      = 6'b001111;
    localparam opcode_t OP_SPECIAL2 = 6'b011100;
    localparam opcode_t OP_SPECIAL3 = 6'b011111;
    localparam opcode_t OP_LB       = 6'b100000;
    localparam opcode_t OP_LH       = 6'b100001;
    localparam opcode_t OP_LW       = 6'b100011;
    localparam opcode_t OP_SB       = 6'b101000;
    localparam opcode_t OP_SH       = 6'b101001;
    localparam opcode_t OP_SW       = 6'b101011;

    localparam funct_t FN_SLL   = 6'b000000;
    localparam funct_t FN_SRL   = 6'b000010;   // rotr when bit 21 set
    localparam funct_t FN_SRA   = 6'b000011;
    localparam funct_t FN_SLLV  = 6'b000100;
    localparam funct_t FN_SRLV  = 6'b000110;   // rotrv when shamt is 1
    localparam funct_t FN_SRAV  = 6'b000111;
    localparam funct_t FN_JR    = 6'b001000;
    localparam funct_t FN_MOVZ  = 6'b001010;
    localparam funct_t FN_MOVN  = 6'b001011;
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MTHI  = 6'b010001;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MTLO  = 6'b010011;
    localparam funct_t FN_MULT  = 6'b011000;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_ADD   = 6'b100000;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUB   = 6'b100010;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;
    localparam funct_t FN_NOR   = 6'b100111;
    localparam funct_t FN_SLT   = 6'b101010;
    localparam funct_t FN_SLTU  = 6'b101011;

    // SPECIAL2 group
    localparam funct_t FN2_MADD = 6'b000000;
    localparam funct_t FN2_MUL  = 6'b000010;
    localparam funct_t FN2_MSUB = 6'b000100;

    localparam regField_t RT_BLTZ = 5'b00000;
    localparam regField_t RT_BGEZ = 5'b00001;
    localparam regField_t SA_SEB  = 5'b10000;
    localparam regField_t SA_SEH  = 5'b11000;

    // Must stay in step with the ALU's own encoding
    localparam aluCode_t ALU_ADD     = 5'd0;
    localparam aluCode_t ALU_SUB     = 5'd1;
    localparam aluCode_t ALU_MULT    = 5'd2;
    localparam aluCode_t ALU_AND     = 5'd3;
    localparam aluCode_t ALU_OR      = 5'd4;
    localparam aluCode_t ALU_NOR     = 5'd5;
    localparam aluCode_t ALU_XOR     = 5'd6;
    localparam aluCode_t ALU_SLL     = 5'd7;
    localparam aluCode_t ALU_SRL     = 5'd8;
    localparam aluCode_t ALU_ROTR    = 5'd9;
    localparam aluCode_t ALU_SLT     = 5'd10;
    localparam aluCode_t ALU_MOVN    = 5'd11;
    localparam aluCode_t ALU_MOVZ    = 5'd12;
    localparam aluCode_t ALU_SRA     = 5'd13;
    localparam aluCode_t ALU_SLTU    = 5'd14;
    localparam aluCode_t ALU_MTHI    = 5'd15;
    localparam aluCode_t ALU_MTLO    = 5'd16;
    localparam aluCode_t ALU_MFHI    = 5'd17;
    localparam aluCode_t ALU_MFLO    = 5'd18;
    localparam aluCode_t ALU_MUL     = 5'd19;
    localparam aluCode_t ALU_MADD    = 5'd20;
    localparam aluCode_t ALU_MSUB    = 5'd21;
    localparam aluCode_t ALU_SEH     = 5'd22;
    localparam aluCode_t ALU_SEB     = 5'd23;
    localparam aluCode_t ALU_BGEZ    = 5'd24;
    localparam aluCode_t ALU_BLTZ    = 5'd25;
    localparam aluCode_t ALU_INVALID = 5'd31;

    localparam regDst_t DST_RT   = 2'd0;
    localparam regDst_t DST_RD   = 2'd1;
    localparam regDst_t DST_LINK = 2'd2;   // r31 for jal

    localparam dataType_t DT_WORD = 2'd0;
    localparam dataType_t DT_HALF = 2'd1;
    localparam dataType_t DT_BYTE = 2'd2;

    localparam hiLoWrite_t HL_NONE = 2'd0;
    localparam hiLoWrite_t HL_HI   = 2'd1;
    localparam hiLoWrite_t HL_LO   = 2'd2;
    localparam hiLoWrite_t HL_BOTH = 2'd3;

endpackage

// ==== decoder/functDecoder.sv ====
module functDecoder (
    input  controlPkg::instr_t       instr,
    output controlPkg::rFormatCtrl_t rCtrl
);
    import controlPkg::*;

    funct_t    funct;
    regField_t shamt;
    logic      rotateSel;

    assign funct     = instr[5:0];
    assign shamt     = instr[10:6];
    assign rotateSel = instr[21];   // The R bit of srl/rotr

    // Opcode is not looked at here; the opcode decoder picks the result up
    // only for SPECIAL
    always_comb begin
        rCtrl         = '0;
        rCtrl.aluCode = ALU_INVALID;

        case (funct)
            FN_ADD, FN_ADDU: rCtrl.aluCode = ALU_ADD;
            FN_SUB:          rCtrl.aluCode = ALU_SUB;
            FN_AND:          rCtrl.aluCode = ALU_AND;
            FN_OR:           rCtrl.aluCode = ALU_OR;
            FN_NOR:          rCtrl.aluCode = ALU_NOR;
            FN_XOR:          rCtrl.aluCode = ALU_XOR;
            FN_SLT:          rCtrl.aluCode = ALU_SLT;
            FN_SLTU:         rCtrl.aluCode = ALU_SLTU;
            FN_MOVN:         rCtrl.aluCode = ALU_MOVN;
            FN_MOVZ:         rCtrl.aluCode = ALU_MOVZ;
            FN_MFHI:         rCtrl.aluCode = ALU_MFHI;
            FN_MFLO:         rCtrl.aluCode = ALU_MFLO;

            FN_MULT, FN_MULTU: begin
                rCtrl.aluCode   = ALU_MULT;
                rCtrl.hiLoWrite = HL_BOTH;   // 64-bit product
            end

            FN_MTHI: begin
                rCtrl.aluCode   = ALU_MTHI;
                rCtrl.hiLoWrite = HL_HI;
            end

            FN_MTLO: begin
                rCtrl.aluCode   = ALU_MTLO;
                rCtrl.hiLoWrite = HL_LO;
            end

            // Immediate shifts take the amount from the shamt field
            FN_SLL: begin
                rCtrl.aluCode     = ALU_SLL;
                rCtrl.aluSrcShamt = 1'b1;
            end

            FN_SRL: begin
                rCtrl.aluCode     = rotateSel ? ALU_ROTR : ALU_SRL;
                rCtrl.aluSrcShamt = 1'b1;
            end

            FN_SRA: begin
                rCtrl.aluCode     = ALU_SRA;
                rCtrl.aluSrcShamt = 1'b1;
            end

            // Variable shifts, amount comes from rs
            FN_SLLV: rCtrl.aluCode = ALU_SLL;
            FN_SRAV: rCtrl.aluCode = ALU_SRA;

            FN_SRLV: begin
                case (shamt)
                    5'd0:    rCtrl.aluCode = ALU_SRL;
                    5'd1:    rCtrl.aluCode = ALU_ROTR;   // rotrv
                    default: rCtrl.aluCode = ALU_INVALID;
                endcase
            end

            // No ALU work for jr, the target is rs
            FN_JR: rCtrl.jumpReg = 1'b1;

            default: rCtrl.aluCode = ALU_INVALID;
        endcase
    end

endmodule

// ==== decoder/opcodeDecoder.sv ====
module opcodeDecoder (
    input  controlPkg::instr_t       instr,
    input  controlPkg::rFormatCtrl_t rCtrl,
    output controlPkg::ctrlWord_t    ctrlNext
);
    import controlPkg::*;

    opcode_t   opcode;
    funct_t    funct;
    regField_t rt;
    regField_t shamt;
    logic      rKnown;       // funct gave a real R-format operation
    dataType_t accessSize;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];
    assign shamt  = instr[10:6];

    assign rKnown = rCtrl.jumpReg || (rCtrl.aluCode != ALU_INVALID);

    // Low opcode bits give the size for both loads and stores
    assign accessSize = opcode[0] ? (opcode[1] ? DT_WORD : DT_HALF) : DT_BYTE;

    always_comb begin
        ctrlNext         = '0;
        ctrlNext.aluCode = ALU_INVALID;

        case (opcode)
            OP_SPECIAL: begin
                if (rKnown) begin
                    ctrlNext.regDst      = DST_RD;
                    ctrlNext.regWrite    = 1'b1;
                    ctrlNext.aluCode     = rCtrl.aluCode;
                    ctrlNext.hiLoWrite   = rCtrl.hiLoWrite;
                    ctrlNext.aluSrcShamt = rCtrl.aluSrcShamt;
                    ctrlNext.jump        = rCtrl.jumpReg;
                end
            end

            OP_SPECIAL2: begin
                case (funct)
                    FN2_MUL:  ctrlNext.aluCode = ALU_MUL;   // GPR result only
                    FN2_MADD: ctrlNext.aluCode = ALU_MADD;
                    FN2_MSUB: ctrlNext.aluCode = ALU_MSUB;
                    default:  ctrlNext.aluCode = ALU_INVALID;
                endcase
                if (ctrlNext.aluCode != ALU_INVALID) begin
                    ctrlNext.regDst   = DST_RD;
                    ctrlNext.regWrite = 1'b1;
                end
                // Accumulating forms update HI and LO
                if (funct == FN2_MADD || funct == FN2_MSUB) begin
                    ctrlNext.hiLoWrite = HL_BOTH;
                end
            end

            OP_LB, OP_LH, OP_LW: begin
                ctrlNext.aluSrcImm = 1'b1;
                ctrlNext.memToReg  = 1'b1;
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.memRead   = 1'b1;
                ctrlNext.dataType  = accessSize;
            end

            OP_SB, OP_SH, OP_SW: begin
                ctrlNext.aluSrcImm = 1'b1;
                ctrlNext.memWrite  = 1'b1;
                ctrlNext.dataType  = accessSize;
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
                ctrlNext.regDst    = DST_RT;
                ctrlNext.aluSrcImm = 1'b1;
                ctrlNext.regWrite  = 1'b1;
            end

            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrlNext.regDst     = DST_RT;
                ctrlNext.aluSrcImm  = 1'b1;
                ctrlNext.regWrite   = 1'b1;
                ctrlNext.signExtend = 1'b1;
            end

            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: ctrlNext.branch = 1'b1;

            OP_REGIMM: begin
                if (rt == RT_BGEZ || rt == RT_BLTZ) begin
                    ctrlNext.branch  = 1'b1;
                    ctrlNext.aluCode = (rt == RT_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
                end
            end

            // seb/seh live in the BSHFL group, picked by shamt
            OP_SPECIAL3: begin
                if (shamt == SA_SEB || shamt == SA_SEH) begin
                    ctrlNext.regDst   = DST_RD;
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.aluCode  = (shamt == SA_SEB) ? ALU_SEB : ALU_SEH;
                end
            end

            OP_J: begin
                ctrlNext.jump        = 1'b1;
                ctrlNext.aluSrcShamt = 1'b1;
            end

            OP_JAL: begin
                ctrlNext.jump        = 1'b1;
                ctrlNext.aluSrcShamt = 1'b1;
                ctrlNext.regWrite    = 1'b1;
                ctrlNext.regDst      = DST_LINK;   // Return address to r31
            end

            default: ctrlNext.aluCode = ALU_INVALID;
        endcase

        // Whole table, including the merged funct result
        assert (!(ctrlNext.branch && ctrlNext.jump))
            else $error("branch and jump both set for opcode %h", opcode);
        assert (!(ctrlNext.memRead && ctrlNext.memWrite))
            else $error("memRead and memWrite both set for opcode %h", opcode);
    end

endmodule

// ==== source/controlRegister.sv ====
module controlRegister (
    input  logic                  clk,
    input  logic                  rstN,
    input  controlPkg::ctrlWord_t ctrlNext,
    input  logic                  instrValid,
    output controlPkg::ctrlWord_t ctrl,
    output logic                  ctrlValid
);

    // Decode to execute boundary
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl      <= '0;
            ctrlValid <= 1'b0;
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrl <= ctrlNext;   // Held between strobes
            end
        end
    end

    // Valid follows the strobe by exactly one cycle
    assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> ctrlValid == $past(instrValid))
        else $error("ctrlValid does not follow instrValid");

endmodule

// ==== source/controller.sv ====
module controller (
    input  logic                  clk,
    input  logic                  rstN,
    input  controlPkg::instr_t    instr,
    input  logic                  instrValid,
    output controlPkg::ctrlWord_t ctrl,
    output logic                  ctrlValid
);
    import controlPkg::*;

    rFormatCtrl_t rCtrl;      // Funct decode, used only for SPECIAL
    ctrlWord_t    ctrlNext;   // Combinational control word

    functDecoder uFunct (
        .instr (instr),
        .rCtrl (rCtrl)
    );

    opcodeDecoder uOpcode (
        .instr    (instr),
        .rCtrl    (rCtrl),
        .ctrlNext (ctrlNext)
    );

    // One cycle from strobe to result
    controlRegister uCtrlReg (
        .clk        (clk),
        .rstN       (rstN),
        .ctrlNext   (ctrlNext),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .ctrlValid  (ctrlValid)
    );

endmodule

// ==== tb/controllerRef.svh ====
`ifndef CONTROLLER_REF_SVH
`define CONTROLLER_REF_SVH

// Galois LFSR, right shift, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

// Expected ALU code for SPECIAL, before the opcode is considered
function automatic aluCode_t specialAluCode(input funct_t fn, input logic rBit,
                                            input regField_t sa);
    case (fn)
        FN_ADD, FN_ADDU:   return ALU_ADD;
        FN_SUB:            return ALU_SUB;
        FN_AND:            return ALU_AND;
        FN_OR:             return ALU_OR;
        FN_NOR:            return ALU_NOR;
        FN_XOR:            return ALU_XOR;
        FN_SLT:            return ALU_SLT;
        FN_SLTU:           return ALU_SLTU;
        FN_MOVN:           return ALU_MOVN;
        FN_MOVZ:           return ALU_MOVZ;
        FN_MFHI:           return ALU_MFHI;
        FN_MFLO:           return ALU_MFLO;
        FN_MTHI:           return ALU_MTHI;
        FN_MTLO:           return ALU_MTLO;
        FN_MULT, FN_MULTU: return ALU_MULT;
        FN_SLL, FN_SLLV:   return ALU_SLL;
        FN_SRA, FN_SRAV:   return ALU_SRA;
        FN_SRL:            return rBit ? ALU_ROTR : ALU_SRL;
        FN_SRLV:           return (sa == 5'd0) ? ALU_SRL : ((sa == 5'd1) ? ALU_ROTR : ALU_INVALID);
        default:           return ALU_INVALID;   // jr lands here too
    endcase
endfunction

function automatic dataType_t accessType(input opcode_t op);
    if (op == OP_LB || op == OP_SB) begin
        return DT_BYTE;
    end
    if (op == OP_LH || op == OP_SH) begin
        return DT_HALF;
    end
    return DT_WORD;
endfunction

function automatic ctrlWord_t refDecode(input instr_t word);
    ctrlWord_t c;
    opcode_t   op;
    funct_t    fn;
    regField_t rt;
    regField_t sa;
    aluCode_t  code;
    op = word[31:26];
    fn = word[5:0];
    rt = word[20:16];
    sa = word[10:6];
    c = '0;
    c.aluCode = ALU_INVALID;
    case (op)
        OP_SPECIAL: begin
            code = specialAluCode(fn, word[21], sa);
            if (fn == FN_JR || code != ALU_INVALID) begin
                c.regDst      = DST_RD;
                c.regWrite    = 1'b1;
                c.aluCode     = code;
                c.jump        = (fn == FN_JR);
                c.aluSrcShamt = (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA);
                if (fn == FN_MULT || fn == FN_MULTU) c.hiLoWrite = HL_BOTH;
                else if (fn == FN_MTHI) c.hiLoWrite = HL_HI;
                else if (fn == FN_MTLO) c.hiLoWrite = HL_LO;
            end
        end
        OP_SPECIAL2: begin
            if (fn == FN2_MUL || fn == FN2_MADD || fn == FN2_MSUB) begin
                c.regDst    = DST_RD;
                c.regWrite  = 1'b1;
                c.aluCode   = (fn == FN2_MUL) ? ALU_MUL : ((fn == FN2_MADD) ? ALU_MADD : ALU_MSUB);
                c.hiLoWrite = (fn == FN2_MUL) ? HL_NONE : HL_BOTH;
            end
        end
        OP_LB, OP_LH, OP_LW: begin
            c.aluSrcImm = 1'b1;
            c.memToReg  = 1'b1;
            c.regWrite  = 1'b1;
            c.memRead   = 1'b1;
            c.dataType  = accessType(op);
        end
        OP_SB, OP_SH, OP_SW: begin
            c.aluSrcImm = 1'b1;
            c.memWrite  = 1'b1;
            c.dataType  = accessType(op);
        end
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI, OP_ANDI, OP_ORI, OP_XORI: begin
            c.regDst     = DST_RT;
            c.aluSrcImm  = 1'b1;
            c.regWrite   = 1'b1;
            c.signExtend = (op == OP_ANDI || op == OP_ORI || op == OP_XORI);
        end
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: c.branch = 1'b1;
        OP_REGIMM: begin
            if (rt == RT_BGEZ || rt == RT_BLTZ) begin
                c.branch  = 1'b1;
                c.aluCode = (rt == RT_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
            end
        end
        OP_SPECIAL3: begin
            if (sa == SA_SEB || sa == SA_SEH) begin
                c.regDst   = DST_RD;
                c.regWrite = 1'b1;
                c.aluCode  = (sa == SA_SEB) ? ALU_SEB : ALU_SEH;
            end
        end
        OP_J, OP_JAL: begin
            c.jump        = 1'b1;
            c.aluSrcShamt = 1'b1;
            if (op == OP_JAL) begin
                c.regWrite = 1'b1;
                c.regDst   = DST_LINK;
            end
        end
        default: c.aluCode = ALU_INVALID;   // Unknown opcode
    endcase
    return c;
endfunction

`endif

// ==== tb/tbController.sv ====
module tbController;
    import controlPkg::*;

    `include "controllerRef.svh"

    localparam int clkPeriod     = 8;
    localparam int resetCycles   = 8;
    localparam int numRandom     = 400;
    localparam int maxGap        = 4;
    localparam int directedBound = 256;
    localparam int timeLimit     =
        (resetCycles + directedBound + numRandom * (1 + maxGap) + 64) * clkPeriod;

    localparam opcode_t listedOps [24] = '{
        OP_SPECIAL, OP_SPECIAL2, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ,
        OP_BGTZ, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_LUI, OP_SPECIAL3, OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW
    };

    // Sub-field selection and an unknown opcode
    localparam instr_t subfieldWords [12] = '{
        {OP_SPECIAL, 5'd0, 5'd8, 5'd9, 5'd4, FN_SRL},           // srl
        {OP_SPECIAL, 5'd1, 5'd8, 5'd9, 5'd4, FN_SRL},           // rotr
        {OP_SPECIAL, 5'd2, 5'd8, 5'd9, 5'd0, FN_SRLV},
        {OP_SPECIAL, 5'd2, 5'd8, 5'd9, 5'd1, FN_SRLV},          // rotrv
        {OP_SPECIAL, 5'd2, 5'd8, 5'd9, 5'd6, FN_SRLV},          // Illegal shamt
        {OP_REGIMM, 5'd3, RT_BGEZ, 16'h0010},
        {OP_REGIMM, 5'd3, RT_BLTZ, 16'h0010},
        {OP_REGIMM, 5'd3, 5'd2, 16'h0010},                      // Illegal rt
        {OP_SPECIAL3, 5'd0, 5'd4, 5'd5, SA_SEB, 6'b100000},
        {OP_SPECIAL3, 5'd0, 5'd4, 5'd5, SA_SEH, 6'b100000},
        {OP_SPECIAL3, 5'd0, 5'd4, 5'd5, 5'd3, 6'b100000},
        {6'b111011, 26'h0123456}
    };

    logic      clk;
    logic      rstN;
    instr_t    instr;
    logic      instrValid;
    ctrlWord_t ctrl;
    logic      ctrlValid;

    logic [31:0] lfsrState = 32'h463c51a6;
    ctrlWord_t   expQ [$];      // Expected words in issue order
    ctrlWord_t   heldCtrl;
    logic        strobeSeen;    // instrValid as the DUT saw it last edge
    int          issuedCount  = 0;
    int          checkedCount = 0;

    controller uut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .ctrlValid  (ctrlValid)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic issueInstr(input instr_t word);
        @(posedge clk);
        instr      <= word;
        instrValid <= 1'b1;
        expQ.push_back(refDecode(word));
        issuedCount++;
    endtask

    // Garbage on instr, which must not reach ctrl
    task automatic idleCycle();
        logic [31:0] junk;
        takeBits(32, junk);
        @(posedge clk);
        instr      <= junk;
        instrValid <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(timeLimit);
        failRun("Timeout: not every issued instruction produced a result in time");
    end

    // Sampled mid-cycle, away from the driving edge
    initial begin
        ctrlWord_t expected;
        heldCtrl   = '0;
        strobeSeen = 1'b0;
        forever begin
            @(negedge clk);
            if (!rstN) begin
                checkValue("ctrlValid", 32'(ctrlValid), 32'd0);
                checkValue("ctrl", 32'(ctrl), 32'd0);
            end else begin
                checkValue("ctrlValid", 32'(ctrlValid), 32'(strobeSeen));
                if (ctrlValid) begin
                    if (expQ.size() == 0) begin
                        failRun("A result came out with no instruction pending");
                    end
                    expected = expQ.pop_front();
                    checkValue("ctrl", 32'(ctrl), 32'(expected));
                    checkedCount++;
                end else begin
                    checkValue("ctrl", 32'(ctrl), 32'(heldCtrl));   // Must hold
                end
            end
            heldCtrl   = ctrl;
            strobeSeen = instrValid;
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] mode;
        logic [31:0] gapOn;
        logic [31:0] gapLen;
        instr      = '0;
        instrValid = 1'b0;
        rstN       = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        idleCycle();
        idleCycle();

        // Every opcode value, listed or not
        for (int op = 0; op < 64; op++) begin
            takeBits(26, word);
            issueInstr({6'(op), word[25:0]});
        end
        for (int fn = 0; fn < 64; fn++) begin
            issueInstr({OP_SPECIAL, 5'd2, 5'd8, 5'd9, 5'd0, 6'(fn)});
            issueInstr({OP_SPECIAL2, 5'd2, 5'd8, 5'd9, 5'd0, 6'(fn)});
        end
        foreach (subfieldWords[i]) begin
            issueInstr(subfieldWords[i]);
        end
        idleCycle();

        // Random words, back to back or with gaps
        for (int n = 0; n < numRandom; n++) begin
            takeBits(32, word);
            takeBits(2, mode);
            if (mode == 32'd1 || mode == 32'd3) begin
                word[31:26] = listedOps[word[4:0] % 5'd24];
            end else if (mode == 32'd2) begin
                word[31:26] = OP_SPECIAL;
            end
            issueInstr(word);
            takeBits(1, gapOn);
            if (gapOn[0]) begin
                takeBits(2, gapLen);
                repeat (gapLen + 1) idleCycle();
            end
        end
        idleCycle();

        while (checkedCount < issuedCount) @(posedge clk);
        repeat (2) @(posedge clk);
        if (checkedCount == issuedCount && expQ.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Result count %0d does not match issue count %0d",
                     checkedCount, issuedCount);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

// ==== project.f ====
+incdir+tb
common/controlPkg.sv
decoder/functDecoder.sv
decoder/opcodeDecoder.sv
source/controlRegister.sv
source/controller.sv
tb/tbController.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbController
RTL_TOP   ?= controller
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

RTL_FILES = common/controlPkg.sv decoder/functDecoder.sv decoder/opcodeDecoder.sv \
            source/controlRegister.sv source/controller.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
